// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the operand fetch testbench with Verilator and run it
# A run that stops early, an assertion stop included, counts as a failure
rm -f sim.log
verilator --binary --assert --timing --timescale 1ns/1ps -f verilog.f \
	--top-module opfetch_tb -o Vopfetch_tb &&
./obj_dir/Vopfetch_tb > sim.log 2>&1 ||
echo "Simulation finished: FAIL" >> sim.log
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && exit 1 || exit 0

// ==== src/decode_ra.sv ====
// A-operand register decoder with implied and alternate stack pointer registers
`timescale 1ns/1ps
`default_nettype none

module decode_ra (
	input wire opfetch_pkg::instr_t ir,
	input wire opfetch_pkg::sp_sel_t sp_sel,
	input wire opfetch_pkg::depth_t istk_depth,
	output opfetch_pkg::reg_idx_t ra
);
	import opfetch_pkg::*;

	// Index before the stack pointer remap
	reg_idx_t ra_raw;

	always_comb
	begin
		case (fld_opcode(ir))
		// Decrement-and-jump always works on the loop counter
		DJMP:
			ra_raw = REG_LC;
		// Stack loads and stores address relative to the stack pointer
		LDSP, STSP:
			ra_raw = REG_SP;
		VM:
		begin
			// Only MTVL reads a general register, other vector mask ops have no A operand
			if (fld_func(ir) == MTVL)
				ra_raw = fld_ra(ir);
			else
				ra_raw = REG_ZERO;
		end
		MFLK:
		begin
			// lk of zero reads as zero, link registers follow the loop counter
			if (fld_lk(ir) == 2'd0)
				ra_raw = REG_ZERO;
			else
				ra_raw = REG_LK_BASE + reg_idx_t'(fld_lk(ir));
		end
		MOV, R2:
			ra_raw = fld_ra(ir);
		OSR2:
		begin
			// Return from interrupt pulls the saved state of the current depth
			if (fld_func(ir) == RTI)
				ra_raw = REG_ISTK_BASE + reg_idx_t'(istk_depth);
			else
				ra_raw = fld_ra(ir);
		end
		default:
			ra_raw = fld_ra(ir);
		endcase
	end

	// Any reference to register 31 goes to the active stack pointer
	assign ra = alt_sp_remap(ra_raw, sp_sel);

endmodule

`default_nettype wire

// ==== src/decode_rb_rt.sv ====
// B-operand and target register decoder
`timescale 1ns/1ps
`default_nettype none

module decode_rb_rt (
	input wire opfetch_pkg::instr_t ir,
	input wire opfetch_pkg::sp_sel_t sp_sel,
	output opfetch_pkg::reg_idx_t rb,
	output opfetch_pkg::reg_idx_t rt
);
	import opfetch_pkg::*;

	// Target before the stack pointer remap
	reg_idx_t rt_raw;

	// Only the two-register forms carry a B operand
	always_comb
	begin
		case (fld_opcode(ir))
		R2, VM:
			rb = fld_rb(ir);
		default:
			rb = REG_ZERO;
		endcase
	end

	always_comb
	begin
		case (fld_opcode(ir))
		// The loop counter is written back after the decrement
		DJMP:
			rt_raw = REG_LC;
		// A stack store writes memory only
		STSP:
			rt_raw = REG_ZERO;
		default:
			rt_raw = fld_rt(ir);
		endcase
	end

	// Same stack pointer redirection as on the A side
	assign rt = alt_sp_remap(rt_raw, sp_sel);

endmodule

`default_nettype wire

// ==== src/opfetch_fsm.sv ====
// Control FSM for the fetch and execute four-phase handshakes
`timescale 1ns/1ps
`default_nettype none

module opfetch_fsm #(
	parameter type operand_pkt_t = logic [145:0],
	// Operand width recovered from the packet, which holds three indices and two values
	localparam int VAL_W = ($bits(operand_pkt_t) - 3 * $bits(opfetch_pkg::reg_idx_t)) / 2
) (
	input wire logic clk,
	input wire logic arst_n,
	input wire logic in_req,
	output logic in_ack,
	input wire opfetch_pkg::fetch_req_t fetch_in,
	output opfetch_pkg::fetch_req_t fetch_q,
	output logic seq_start,
	input wire logic seq_done,
	input wire logic [VAL_W-1:0] a_val,
	input wire logic [VAL_W-1:0] b_val,
	input wire opfetch_pkg::reg_idx_t ra,
	input wire opfetch_pkg::reg_idx_t rb,
	input wire opfetch_pkg::reg_idx_t rt,
	output logic out_req,
	input wire logic out_ack,
	output operand_pkt_t pkt
);

	typedef enum logic [1:0] {
		IDLE,
		READ,
		PRESENT,
		DRAIN
	} state_e;

	state_e state;
	logic capture;
	logic load_pkt;

	// A new request is taken only when the previous input handshake is fully closed
	assign capture = (state == IDLE) && in_req && !in_ack;
	assign load_pkt = (state == READ) && seq_done;

	// ====================
	// Control
	// ====================

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= IDLE;
			in_ack <= 1'b0;
			seq_start <= 1'b0;
			out_req <= 1'b0;
		end
		else
		begin
			// Start pulse lasts exactly the cycle after capture
			seq_start <= capture;
			// Acknowledge one cycle after capture, release once fetch drops in_req
			if (seq_start)
				in_ack <= 1'b1;
			else if (!in_req)
				in_ack <= 1'b0;
			case (state)
			IDLE:
				if (capture)
					state <= READ;
			READ:
				if (seq_done)
				begin
					out_req <= 1'b1;
					state <= PRESENT;
				end
			PRESENT:
				if (out_ack)
				begin
					out_req <= 1'b0;
					state <= DRAIN;
				end
			// Wait for both low phases before accepting more work
			DRAIN:
				if (!out_ack && !in_ack)
					state <= IDLE;
			default:
				state <= IDLE;
			endcase
		end
	end

	// ====================
	// Payload
	// ====================

	// Packet order is ra, rb, rt, a_val, b_val as in the packet struct
	always_ff @(posedge clk)
	begin
		if (capture)
			fetch_q <= fetch_in;
		if (load_pkt)
			pkt <= operand_pkt_t'({ra, rb, rt, a_val, b_val});
	end

endmodule

`default_nettype wire

// ==== src/opfetch_pkg.sv ====
// Operand fetch stage shared types, instruction field helpers and register map
`default_nettype none

package opfetch_pkg;

	// ====================
	// Basic vector types
	// ====================

	// Raw 32-bit instruction word as delivered by fetch
	typedef logic [31:0] instr_t;
	// Physical register index, covers general and special registers
	typedef logic [5:0] reg_idx_t;
	// Alternate stack pointer select, 0 means the normal stack pointer
	typedef logic [2:0] sp_sel_t;
	// Current interrupt nesting depth
	typedef logic [2:0] depth_t;

	localparam int NUM_REGS = 64;

	// Major opcodes in bits 6..0, anything not listed decodes as a plain register op
	typedef enum logic [6:0] {
		R2   = 7'h02,
		MOV  = 7'h0D,
		OSR2 = 7'h0C,
		VM   = 7'h0F,
		DJMP = 7'h22,
		MFLK = 7'h2A,
		LDSP = 7'h50,
		STSP = 7'h58
	} opcode_e;

	// Function codes in bits 31..25, meaning depends on the major opcode
	typedef enum logic [6:0] {
		RTI  = 7'h19,
		MTVL = 7'h2D
	} func_e;

	// ====================
	// Register index space
	// ====================

	localparam reg_idx_t REG_ZERO = 6'd0;
	localparam reg_idx_t REG_SP = 6'd31;
	localparam reg_idx_t REG_LC = 6'd40;
	// Link registers sit at base plus lk, so lk values 1 to 3 give 41 to 43
	localparam reg_idx_t REG_LK_BASE = 6'd40;
	// Alternate stack pointers sit at base plus sp_sel for sp_sel 1 to 4
	localparam reg_idx_t REG_ALT_SP_BASE = 6'd43;
	// One interrupt stack slot per nesting depth
	localparam reg_idx_t REG_ISTK_BASE = 6'd48;

	// Request from fetch, held stable by fetch while in_req is high
	typedef struct packed {
		instr_t instr;
		sp_sel_t sp_sel;
		depth_t istk_depth;
	} fetch_req_t;

	// ====================
	// Field extraction
	// ====================

	function automatic logic [6:0] fld_opcode(instr_t ir);
		return ir[6:0];
	endfunction

	function automatic logic [6:0] fld_func(instr_t ir);
		return ir[31:25];
	endfunction

	// Register fields are five bits wide and index only the general registers
	function automatic reg_idx_t fld_rt(instr_t ir);
		return {1'b0, ir[11:7]};
	endfunction

	function automatic reg_idx_t fld_ra(instr_t ir);
		return {1'b0, ir[16:12]};
	endfunction

	function automatic reg_idx_t fld_rb(instr_t ir);
		return {1'b0, ir[21:17]};
	endfunction

	// Link selector overlaps the upper ra bits and only means something for MFLK
	function automatic logic [1:0] fld_lk(instr_t ir);
		return ir[15:14];
	endfunction

	// Redirects a stack pointer reference to the selected alternate stack pointer
	function automatic reg_idx_t alt_sp_remap(reg_idx_t idx, sp_sel_t sel);
		alt_sp_remap = idx;
		if (idx == REG_SP && sel >= 3'd1 && sel <= 3'd4)
			alt_sp_remap = REG_ALT_SP_BASE + reg_idx_t'(sel);
	endfunction

endpackage

`default_nettype wire

// ==== src/opfetch_top.sv ====
// Operand fetch stage top level, decoders plus register file, sequencer and FSM
`timescale 1ns/1ps
`default_nettype none

module opfetch_top #(
	parameter int DATA_W = 64,
	localparam int IDX_W = $bits(opfetch_pkg::reg_idx_t),
	localparam int WB_W = 1 + IDX_W + DATA_W,
	localparam int PKT_W = 3 * IDX_W + 2 * DATA_W
) (
	input wire logic clk,
	input wire logic arst_n,
	input wire logic in_req,
	output logic in_ack,
	input wire opfetch_pkg::fetch_req_t fetch_in,
	// Laid out as wb_t, enable in the top bit
	input wire logic [WB_W-1:0] wb,
	output logic out_req,
	input wire logic out_ack,
	// Laid out as operand_pkt_t, ra in the top bits
	output logic [PKT_W-1:0] pkt
);
	import opfetch_pkg::*;

	typedef struct packed {
		reg_idx_t ra;
		reg_idx_t rb;
		reg_idx_t rt;
		logic [DATA_W-1:0] a_val;
		logic [DATA_W-1:0] b_val;
	} operand_pkt_t;

	typedef struct packed {
		logic en;
		reg_idx_t idx;
		logic [DATA_W-1:0] data;
	} wb_t;

	fetch_req_t fetch_q;
	reg_idx_t ra;
	reg_idx_t rb;
	reg_idx_t rt;
	reg_idx_t rd_idx;
	logic [DATA_W-1:0] rd_data;
	logic [DATA_W-1:0] a_val;
	logic [DATA_W-1:0] b_val;
	logic seq_start;
	logic seq_done;

	// Decoders look at the captured request so indices stay put for the whole read
	decode_ra decode_ra_inst (
		.ir(fetch_q.instr),
		.sp_sel(fetch_q.sp_sel),
		.istk_depth(fetch_q.istk_depth),
		.ra(ra)
	);

	decode_rb_rt decode_rb_rt_inst (
		.ir(fetch_q.instr),
		.sp_sel(fetch_q.sp_sel),
		.rb(rb),
		.rt(rt)
	);

	regfile #(
		.DATA_W(DATA_W),
		.wb_t(wb_t)
	) regfile_inst (
		.clk(clk),
		.arst_n(arst_n),
		.rd_idx(rd_idx),
		.rd_data(rd_data),
		.wb(wb)
	);

	read_sequencer #(
		.DATA_W(DATA_W)
	) read_sequencer_inst (
		.clk(clk),
		.arst_n(arst_n),
		.start(seq_start),
		.ra(ra),
		.rb(rb),
		.rd_idx(rd_idx),
		.rd_data(rd_data),
		.a_val(a_val),
		.b_val(b_val),
		.done(seq_done)
	);

	opfetch_fsm #(
		.operand_pkt_t(operand_pkt_t)
	) opfetch_fsm_inst (
		.clk(clk),
		.arst_n(arst_n),
		.in_req(in_req),
		.in_ack(in_ack),
		.fetch_in(fetch_in),
		.fetch_q(fetch_q),
		.seq_start(seq_start),
		.seq_done(seq_done),
		.a_val(a_val),
		.b_val(b_val),
		.ra(ra),
		.rb(rb),
		.rt(rt),
		.out_req(out_req),
		.out_ack(out_ack),
		.pkt(pkt)
	);

endmodule

`default_nettype wire

// ==== src/read_sequencer.sv ====
// Two-step sequencer that shares one read port between the A and B operands
`timescale 1ns/1ps
`default_nettype none

module read_sequencer #(
	parameter int DATA_W = 64
) (
	input wire logic clk,
	input wire logic arst_n,
	input wire logic start,
	input wire opfetch_pkg::reg_idx_t ra,
	input wire opfetch_pkg::reg_idx_t rb,
	output opfetch_pkg::reg_idx_t rd_idx,
	input wire logic [DATA_W-1:0] rd_data,
	output logic [DATA_W-1:0] a_val,
	output logic [DATA_W-1:0] b_val,
	output logic done
);

	// Low while reading A or idle, high while reading B
	logic step;

	assign rd_idx = step ? rb : ra;

	// The start cycle reads A, the next one reads B, then done is high for one cycle
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			step <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			done <= step;
			if (step)
				step <= 1'b0;
			else if (start)
				step <= 1'b1;
		end
	end

	// Operand latches
	always_ff @(posedge clk)
	begin
		if (!step && start)
			a_val <= rd_data;
		if (step)
			b_val <= rd_data;
	end

endmodule

`default_nettype wire

// ==== src/regfile.sv ====
// Register file with one combinational read port and one write-back port
`timescale 1ns/1ps
`default_nettype none

module regfile #(
	parameter int DATA_W = 64,
	parameter type wb_t = logic
) (
	input wire logic clk,
	input wire logic arst_n,
	input wire opfetch_pkg::reg_idx_t rd_idx,
	output logic [DATA_W-1:0] rd_data,
	input wire wb_t wb
);
	import opfetch_pkg::*;

	logic [DATA_W-1:0] mem [NUM_REGS];

	// ====================
	// Write-back port
	// ====================

	// The whole array starts out as zero
	// A write becomes visible to the read port right after the edge it lands on
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < NUM_REGS; i++)
				mem[i] <= '0;
		end
		else if (wb.en && wb.idx != REG_ZERO)
		begin
			mem[wb.idx] <= wb.data;
		end
	end

	// ====================
	// Read port
	// ====================

	// Register 0 is hardwired to zero regardless of the array contents
	assign rd_data = (rd_idx == REG_ZERO) ? '0 : mem[rd_idx];

endmodule

`default_nettype wire

// ==== verification/opfetch_assertions.sv ====
// Handshake and packet stability checks for the operand fetch FSM
`timescale 1ns/1ps
`default_nettype none

module opfetch_assertions #(
	parameter int PKT_W = 146
) (
	input wire logic clk,
	input wire logic arst_n,
	input wire logic in_req,
	input wire logic in_ack,
	input wire logic out_req,
	input wire logic out_ack,
	input wire logic [PKT_W-1:0] pkt
);

	// Once the packet is offered it stays offered until execute answers
	out_req_held: assert property (@(posedge clk) disable iff (!arst_n)
		out_req && !out_ack |=> out_req)
		else $error("out_req dropped before out_ack was seen");

	// The packet only changes while out_req is low
	pkt_stable: assert property (@(posedge clk) disable iff (!arst_n)
		out_req |=> !out_req || $stable(pkt))
		else $error("pkt changed while out_req was high");

	// in_ack answers a request, so in_req must be up when it rises
	in_ack_answers: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(in_ack) |-> in_req)
		else $error("in_ack rose while in_req was low");

endmodule

bind opfetch_fsm opfetch_assertions #(
	.PKT_W($bits(operand_pkt_t))
) opfetch_assertions_inst (
	.clk(clk),
	.arst_n(arst_n),
	.in_req(in_req),
	.in_ack(in_ack),
	.out_req(out_req),
	.out_ack(out_ack),
	.pkt(pkt)
);

`default_nettype wire

// ==== verification/opfetch_tb.sv ====
// Directed testbench for the operand fetch stage with a reference index decoder
`timescale 1ns/1ps
`default_nettype none

module opfetch_tb;
	import opfetch_pkg::*;

	localparam int DATA_W = 64;
	localparam int IDX_W = $bits(reg_idx_t);
	localparam int WB_W = 1 + IDX_W + DATA_W;
	localparam int PKT_W = 3 * IDX_W + 2 * DATA_W;
	localparam int WAIT_MAX = 20;
	// Cycles that execute keeps out_ack high after out_req has dropped
	localparam int ACK_HOLD = 4;
	// Transactions per test for general, implied, alternate SP, RTI, write-back and back-pressure
	localparam int N_TRANS = 9 + 9 + 24 + 8 + 5 + 4;

	// Same layout as the packet at the DUT boundary with ra in the top bits
	typedef struct packed {
		reg_idx_t ra;
		reg_idx_t rb;
		reg_idx_t rt;
		logic [DATA_W-1:0] a_val;
		logic [DATA_W-1:0] b_val;
	} pkt_view_t;

	logic clk = 1'b0;
	logic arst_n;
	logic in_req;
	logic in_ack;
	fetch_req_t fetch_in;
	logic [WB_W-1:0] wb;
	logic out_req;
	logic out_ack;
	logic [PKT_W-1:0] pkt;

	// Expected register contents
	// Entry 0 is never written
	logic [DATA_W-1:0] shadow [64];
	logic [31:0] lcg_state = 32'd55;
	int value_errors = 0;
	int proto_errors = 0;

	opfetch_top #(
		.DATA_W(DATA_W)
	) opfetch_top_inst (
		.clk(clk),
		.arst_n(arst_n),
		.in_req(in_req),
		.in_ack(in_ack),
		.fetch_in(fetch_in),
		.wb(wb),
		.out_req(out_req),
		.out_ack(out_ack),
		.pkt(pkt)
	);

	always #2 clk = ~clk;

	// ====================
	// Stimulus helpers
	// ====================

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [DATA_W-1:0] rand_data();
		logic [63:0] wide;
		wide[63:32] = next_rand();
		wide[31:0] = next_rand();
		return wide[DATA_W-1:0];
	endfunction

	function automatic instr_t make_instr(logic [6:0] op, logic [6:0] func, logic [4:0] ra_f,
		logic [4:0] rb_f, logic [4:0] rt_f);
		return {func, 3'b000, rb_f, ra_f, rt_f, op};
	endfunction

	function automatic fetch_req_t make_req(instr_t ir, sp_sel_t sel, depth_t depth);
		fetch_req_t req;
		req.instr = ir;
		req.sp_sel = sel;
		req.istk_depth = depth;
		return req;
	endfunction

	// ====================
	// Reference model
	// ====================

	// Register 31 moves to 44..47 when sp_sel picks an alternate stack
	function automatic reg_idx_t remap_sp(reg_idx_t idx, sp_sel_t sel);
		if (idx == 6'd31 && sel >= 3'd1 && sel <= 3'd4)
			return 6'd43 + {3'd0, sel};
		return idx;
	endfunction

	function automatic reg_idx_t ref_ra(instr_t ir, sp_sel_t sel, depth_t depth);
		reg_idx_t idx;
		idx = {1'b0, ir[16:12]};
		case (ir[6:0])
		DJMP:
			idx = 6'd40;
		LDSP, STSP:
			idx = 6'd31;
		VM:
			if (ir[31:25] != MTVL)
				idx = 6'd0;
		MFLK:
			idx = (ir[15:14] == 2'd0) ? 6'd0 : 6'd40 + {4'd0, ir[15:14]};
		OSR2:
			if (ir[31:25] == RTI)
				idx = 6'd48 + {3'd0, depth};
		default:
			idx = {1'b0, ir[16:12]};
		endcase
		return remap_sp(idx, sel);
	endfunction

	function automatic reg_idx_t ref_rb(instr_t ir);
		if (ir[6:0] == R2 || ir[6:0] == VM)
			return {1'b0, ir[21:17]};
		return 6'd0;
	endfunction

	function automatic reg_idx_t ref_rt(instr_t ir, sp_sel_t sel);
		reg_idx_t idx;
		idx = {1'b0, ir[11:7]};
		if (ir[6:0] == DJMP)
			idx = 6'd40;
		else if (ir[6:0] == STSP)
			idx = 6'd0;
		return remap_sp(idx, sel);
	endfunction

	function automatic logic [DATA_W-1:0] read_shadow(reg_idx_t idx);
		return (idx == 6'd0) ? '0 : shadow[idx];
	endfunction

	// ====================
	// Compare tasks
	// ====================

	task automatic check_idx(input string name, input reg_idx_t exp, input reg_idx_t act);
		if (act !== exp)
		begin
			value_errors++;
			$display("Fail %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
		input logic [DATA_W-1:0] act);
		if (act !== exp)
		begin
			value_errors++;
			$display("Fail %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	// ====================
	// Bus tasks
	// ====================

	// The write lands on the edge after it is driven
	task automatic write_reg(input reg_idx_t idx, input logic [DATA_W-1:0] data);
		@(posedge clk);
		wb <= {1'b1, idx, data};
		@(posedge clk);
		wb <= '0;
		if (idx != 6'd0)
			shadow[idx] = data;
	endtask

	task automatic wait_in_ack(input logic level, input string name);
		int n;
		n = 0;
		@(posedge clk);
		while (in_ack !== level && n < WAIT_MAX)
		begin
			@(posedge clk);
			n++;
		end
		if (in_ack !== level)
		begin
			proto_errors++;
			$display("Error %s: in_ack did not go to %0d within %0d cycles", name, level,
				WAIT_MAX);
		end
	endtask

	task automatic wait_out_req(input logic level, input string name);
		int n;
		n = 0;
		@(posedge clk);
		while (out_req !== level && n < WAIT_MAX)
		begin
			@(posedge clk);
			n++;
		end
		if (out_req !== level)
		begin
			proto_errors++;
			$display("Error %s: out_req did not go to %0d within %0d cycles", name, level,
				WAIT_MAX);
		end
	endtask

	// Full four-phase exchange on both sides
	// With early set, the next request is raised while execute still holds off out_ack
	task automatic run_instr(input string name, input fetch_req_t req, input int ack_delay,
		input logic early, input fetch_req_t next_req);
		pkt_view_t got;
		pkt_view_t held;
		reg_idx_t exp_ra;
		reg_idx_t exp_rb;
		exp_ra = ref_ra(req.instr, req.sp_sel, req.istk_depth);
		exp_rb = ref_rb(req.instr);
		@(posedge clk);
		fetch_in <= req;
		in_req <= 1'b1;
		wait_in_ack(1'b1, name);
		in_req <= 1'b0;
		wait_in_ack(1'b0, name);
		wait_out_req(1'b1, name);
		held = pkt;
		check_idx({name, " ra"}, exp_ra, held.ra);
		check_idx({name, " rb"}, exp_rb, held.rb);
		check_idx({name, " rt"}, ref_rt(req.instr, req.sp_sel), held.rt);
		check_data({name, " a_val"}, read_shadow(exp_ra), held.a_val);
		check_data({name, " b_val"}, read_shadow(exp_rb), held.b_val);
		if (early)
		begin
			fetch_in <= next_req;
			in_req <= 1'b1;
		end
		repeat (ack_delay)
		begin
			@(posedge clk);
			got = pkt;
			if (got != held)
			begin
				proto_errors++;
				$display("Error %s: packet changed while waiting for out_ack", name);
			end
			if (in_ack)
			begin
				proto_errors++;
				$display("Error %s: in_ack rose before out_ack had fallen", name);
			end
		end
		out_ack <= 1'b1;
		wait_out_req(1'b0, name);
		// Execute keeps out_ack up a while longer and the next request stays unanswered
		repeat (ACK_HOLD)
		begin
			@(posedge clk);
			if (in_ack)
			begin
				proto_errors++;
				$display("Error %s: in_ack rose before out_ack had fallen", name);
			end
		end
		out_ack <= 1'b0;
	endtask

	task automatic issue(input string name, input instr_t ir, input sp_sel_t sel,
		input depth_t depth);
		run_instr(name, make_req(ir, sel, depth), 0, 1'b0, '0);
	endtask

	// ====================
	// Tests
	// ====================

	task automatic test_general();
		logic [31:0] r;
		for (int i = 0; i < 8; i++)
		begin
			r = next_rand();
			issue($sformatf("general_%0d", i), make_instr((i % 2 == 0) ? R2 : MOV, r[31:25],
				r[16:12], r[21:17], r[11:7]), 3'd0, r[2:0]);
		end
		// Both operands from register 0
		issue("general_zero", make_instr(R2, 7'd0, 5'd0, 5'd0, 5'd3), 3'd0, 3'd0);
	endtask

	task automatic test_implied();
		logic [31:0] r;
		r = next_rand();
		issue("implied_djmp", make_instr(DJMP, r[31:25], r[16:12], r[21:17], r[11:7]),
			3'd0, 3'd0);
		issue("implied_ldsp", make_instr(LDSP, r[31:25], r[16:12], r[21:17], r[11:7]),
			3'd0, 3'd0);
		issue("implied_stsp", make_instr(STSP, r[31:25], r[16:12], r[21:17], r[11:7]),
			3'd0, 3'd0);
		for (int l = 0; l < 4; l++)
		begin
			r = next_rand();
			// lk sits in ra field bits 3..2
			issue($sformatf("implied_mflk_lk%0d", l), make_instr(MFLK, r[31:25],
				{r[16], l[1:0], r[13:12]}, r[21:17], r[11:7]), 3'd0, 3'd0);
		end
		issue("implied_vm_mtvl", make_instr(VM, MTVL, r[16:12], r[21:17], r[11:7]),
			3'd0, 3'd0);
		issue("implied_vm_other", make_instr(VM, 7'h01, r[16:12], r[21:17], r[11:7]),
			3'd0, 3'd0);
	endtask

	task automatic test_alt_sp();
		logic [31:0] r;
		for (int s = 0; s < 8; s++)
		begin
			r = next_rand();
			issue($sformatf("alt_sp_ldsp_sel%0d", s), make_instr(LDSP, r[31:25], r[16:12],
				r[21:17], r[11:7]), s[2:0], 3'd0);
			issue($sformatf("alt_sp_stsp_sel%0d", s), make_instr(STSP, r[31:25], r[16:12],
				r[21:17], r[11:7]), s[2:0], 3'd0);
			issue($sformatf("alt_sp_r2_sel%0d", s), make_instr(R2, r[31:25], 5'd31,
				r[21:17], r[11:7]), s[2:0], 3'd0);
		end
	endtask

	task automatic test_rti();
		logic [31:0] r;
		for (int d = 0; d < 8; d++)
		begin
			r = next_rand();
			issue($sformatf("rti_depth%0d", d), make_instr(OSR2, RTI, r[16:12], r[21:17],
				r[11:7]), 3'd0, d[2:0]);
		end
	endtask

	task automatic test_writeback();
		write_reg(6'd40, rand_data());
		write_reg(6'd44, rand_data());
		write_reg(6'd48, rand_data());
		write_reg(6'd41, rand_data());
		write_reg(6'd7, rand_data());
		write_reg(6'd0, rand_data());
		issue("wb_loop_counter", make_instr(DJMP, 7'd0, 5'd0, 5'd0, 5'd0), 3'd0, 3'd0);
		issue("wb_alt_sp", make_instr(LDSP, 7'd0, 5'd0, 5'd0, 5'd2), 3'd1, 3'd0);
		issue("wb_istk", make_instr(OSR2, RTI, 5'd0, 5'd0, 5'd0), 3'd0, 3'd0);
		issue("wb_link", make_instr(MFLK, 7'd0, 5'b00100, 5'd0, 5'd4), 3'd0, 3'd0);
		issue("wb_zero", make_instr(R2, 7'd0, 5'd7, 5'd0, 5'd5), 3'd0, 3'd0);
	endtask

	task automatic test_backpressure();
		fetch_req_t reqs [4];
		logic [31:0] r;
		int delay;
		for (int i = 0; i < 4; i++)
		begin
			r = next_rand();
			reqs[i] = make_req(make_instr(R2, r[31:25], r[16:12], r[21:17], r[11:7]),
				3'd0, 3'd0);
		end
		for (int i = 0; i < 4; i++)
		begin
			r = next_rand();
			delay = {28'd0, r[27:24]} + 1;
			if (i < 3)
				run_instr($sformatf("backpressure_%0d", i), reqs[i], delay, 1'b1, reqs[i + 1]);
			else
				run_instr($sformatf("backpressure_%0d", i), reqs[i], delay, 1'b0, '0);
		end
	endtask

	// ====================
	// Run control
	// ====================

	// Each transaction finishes far inside 50 cycles even with the preload included
	initial
	begin
		repeat (N_TRANS * 50) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the tests did not complete",
			N_TRANS * 50);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial
	begin
		arst_n = 1'b0;
		in_req = 1'b0;
		out_ack = 1'b0;
		fetch_in = '0;
		wb = '0;
		for (int i = 0; i < 64; i++)
			shadow[i] = '0;
		repeat (3) @(posedge clk);
		arst_n <= 1'b1;
		// Random contents everywhere so every index has a distinct value
		for (int i = 1; i < 64; i++)
			write_reg(reg_idx_t'(i), rand_data());
		test_general();
		test_implied();
		test_alt_sp();
		test_rti();
		test_writeback();
		test_backpressure();
		$display("Errors: %0d value mismatches, %0d protocol errors", value_errors,
			proto_errors);
		if (value_errors == 0 && proto_errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
src/opfetch_pkg.sv
src/decode_ra.sv
src/decode_rb_rt.sv
src/regfile.sv
src/read_sequencer.sv
src/opfetch_fsm.sv
src/opfetch_top.sv
verification/opfetch_assertions.sv
verification/opfetch_tb.sv
